/* src/isa_pkg.sv */
// instruction-set definitions used by the rename front: classes, exception codes, levels
package isa_pkg;

  // ====================
  // instruction classes
  // ====================
  typedef enum logic [2:0] {
    CLS_ALU     = 3'd0,
    CLS_MDU     = 3'd1,
    CLS_MEM     = 3'd2,
    CLS_BR      = 3'd3,
    CLS_PRIV    = 3'd4,
    CLS_SYSCALL = 3'd5,
    CLS_BREAK   = 3'd6
  } instr_class_e;

  // exception codes as the architecture numbers them
  typedef enum logic [5:0] {
    ECODE_INT = 6'h00,
    ECODE_SYS = 6'h0b,
    ECODE_BRK = 6'h0c,
    ECODE_INE = 6'h0d,
    ECODE_IPE = 6'h0e
  } ecode_e;

  // lowest privilege, priv class traps here
  localparam logic [1:0] PLV_USER = 2'd3;

endpackage

/* src/sched_pkg.sv */
// rename front pipeline widths, register index types and per-slot structs
package sched_pkg;

  localparam int DECODE_WIDTH = 2;
  localparam int ARCH_REG_NUM = 32;
  localparam int PHY_REG_NUM  = 64;

  // free list covers every register outside the reset mapping
  localparam int FL_DEPTH = PHY_REG_NUM - ARCH_REG_NUM;
  localparam int FL_IDX_W = $clog2(FL_DEPTH);
  localparam int FL_CNT_W = $clog2(FL_DEPTH + 1);

  typedef logic [$clog2(ARCH_REG_NUM)-1:0] arch_reg_t;
  typedef logic [$clog2(PHY_REG_NUM)-1:0]  phys_reg_t;

  // ====================
  // per-slot structs
  // ====================
  typedef struct packed {
    logic                  valid;
    isa_pkg::instr_class_e cls;
    logic                  invalid;
    arch_reg_t             arch_src0;
    arch_reg_t             arch_src1;
    arch_reg_t             arch_dest;
  } rename_req_t;

  typedef struct packed {
    logic            valid;
    isa_pkg::ecode_e ecode;
  } excp_t;

  typedef struct packed {
    phys_reg_t psrc0;
    phys_reg_t psrc1;
    logic      src0_ready;
    logic      src1_ready;
    logic      dest_valid;
    phys_reg_t pdest;
    phys_reg_t old_pdest;
  } renamed_t;

  typedef struct packed {
    logic                  valid;
    isa_pkg::instr_class_e cls;
    arch_reg_t             arch_dest;
    phys_reg_t             pdest;
    phys_reg_t             old_pdest;
    excp_t                 excp;
  } rob_entry_t;

  typedef struct packed {
    logic                  valid;
    isa_pkg::instr_class_e cls;
    renamed_t              renamed;
  } dispatch_entry_t;

endpackage

/* src/free_list.sv */
// free list of physical registers, circular queue with multi-slot pop and one push
`timescale 1ns/10ps

module free_list (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic [sched_pkg::DECODE_WIDTH-1:0]              alloc_i,
  input  logic                                            free_valid_i,
  input  sched_pkg::phys_reg_t                            free_preg_i,
  output logic                                            ready_o,
  output sched_pkg::phys_reg_t [sched_pkg::DECODE_WIDTH-1:0] preg_o
);

  import sched_pkg::*;

  phys_reg_t           fl_q [FL_DEPTH];
  logic [FL_IDX_W-1:0] head_q;
  logic [FL_IDX_W-1:0] tail_q;
  logic [FL_CNT_W-1:0] count_q;

  logic [FL_IDX_W-1:0] rd_idx;
  logic [FL_CNT_W-1:0] alloc_cnt;

  // whole group must fit, independent of how many slots allocate
  assign ready_o = count_q >= FL_CNT_W'(DECODE_WIDTH);

  // each slot sees the entry after the ones popped by earlier slots
  always_comb begin
    rd_idx    = head_q;
    alloc_cnt = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      preg_o[i] = fl_q[rd_idx];
      rd_idx    = rd_idx + FL_IDX_W'(alloc_i[i]);
      alloc_cnt = alloc_cnt + FL_CNT_W'(alloc_i[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // registers above the identity map start out free, ascending
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_q[i] <= phys_reg_t'(ARCH_REG_NUM + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= FL_CNT_W'(FL_DEPTH);
    end else begin
      head_q  <= rd_idx;
      count_q <= count_q - alloc_cnt + FL_CNT_W'(free_valid_i);
      if (free_valid_i) begin
        fl_q[tail_q] <= free_preg_i;
        tail_q       <= tail_q + 1'b1;
      end
    end
  end

endmodule

/* src/reg_alias_table.sv */
// register alias table, arch to phys map plus ready bit per physical register
`timescale 1ns/10ps

module reg_alias_table (
  input  logic                                               clk,
  input  logic                                               rst_n,
  input  sched_pkg::arch_reg_t [sched_pkg::DECODE_WIDTH-1:0] src0_i,
  input  sched_pkg::arch_reg_t [sched_pkg::DECODE_WIDTH-1:0] src1_i,
  input  sched_pkg::arch_reg_t [sched_pkg::DECODE_WIDTH-1:0] dest_i,
  input  logic [sched_pkg::DECODE_WIDTH-1:0]                 we_i,
  input  sched_pkg::phys_reg_t [sched_pkg::DECODE_WIDTH-1:0] wpreg_i,
  input  logic                                               wb_valid_i,
  input  sched_pkg::phys_reg_t                               wb_preg_i,
  output sched_pkg::phys_reg_t [sched_pkg::DECODE_WIDTH-1:0] psrc0_o,
  output sched_pkg::phys_reg_t [sched_pkg::DECODE_WIDTH-1:0] psrc1_o,
  output logic [sched_pkg::DECODE_WIDTH-1:0]                 ready0_o,
  output logic [sched_pkg::DECODE_WIDTH-1:0]                 ready1_o,
  output sched_pkg::phys_reg_t [sched_pkg::DECODE_WIDTH-1:0] old_pdest_o
);

  import sched_pkg::*;

  phys_reg_t              map_q [ARCH_REG_NUM];
  logic [PHY_REG_NUM-1:0] rdy_q;

  // lookups see the table as it stood before this edge
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      psrc0_o[i]     = map_q[src0_i[i]];
      psrc1_o[i]     = map_q[src1_i[i]];
      ready0_o[i]    = rdy_q[map_q[src0_i[i]]];
      ready1_o[i]    = rdy_q[map_q[src1_i[i]]];
      old_pdest_o[i] = map_q[dest_i[i]];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int a = 0; a < ARCH_REG_NUM; a++) begin
        map_q[a] <= phys_reg_t'(a);
      end
      rdy_q <= '1;
    end else begin
      if (wb_valid_i) begin
        rdy_q[wb_preg_i] <= 1'b1;
      end
      // later slot overrides an earlier write to the same entry
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        if (we_i[i]) begin
          map_q[dest_i[i]]  <= wpreg_i[i];
          rdy_q[wpreg_i[i]] <= 1'b0;
        end
      end
    end
  end

endmodule

/* src/rename_unit.sv */
// rename unit, free list and alias table with same-group dependency bypass
`timescale 1ns/10ps

module rename_unit (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  sched_pkg::rename_req_t [sched_pkg::DECODE_WIDTH-1:0] req_i,
  input  logic                                                 fire_i,
  input  logic                                                 free_valid_i,
  input  sched_pkg::phys_reg_t                                 free_preg_i,
  input  logic                                                 wb_valid_i,
  input  sched_pkg::phys_reg_t                                 wb_preg_i,
  output logic                                                 ready_o,
  output sched_pkg::renamed_t [sched_pkg::DECODE_WIDTH-1:0]    renamed_o
);

  import sched_pkg::*;

  logic [DECODE_WIDTH-1:0]      dest_vld;
  logic [DECODE_WIDTH-1:0]      alloc;
  arch_reg_t [DECODE_WIDTH-1:0] src0_arch;
  arch_reg_t [DECODE_WIDTH-1:0] src1_arch;
  arch_reg_t [DECODE_WIDTH-1:0] dest_arch;
  phys_reg_t [DECODE_WIDTH-1:0] fl_preg;
  phys_reg_t [DECODE_WIDTH-1:0] rat_psrc0;
  phys_reg_t [DECODE_WIDTH-1:0] rat_psrc1;
  logic [DECODE_WIDTH-1:0]      rat_ready0;
  logic [DECODE_WIDTH-1:0]      rat_ready1;
  phys_reg_t [DECODE_WIDTH-1:0] rat_old;

  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      src0_arch[i] = req_i[i].arch_src0;
      src1_arch[i] = req_i[i].arch_src1;
      dest_arch[i] = req_i[i].arch_dest;
      // r0 is never renamed
      dest_vld[i]  = req_i[i].valid & (req_i[i].arch_dest != '0);
      alloc[i]     = dest_vld[i] & fire_i;
    end
  end

  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_i      (alloc),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .ready_o      (ready_o),
    .preg_o       (fl_preg)
  );

  reg_alias_table u_rat (
    .clk         (clk),
    .rst_n       (rst_n),
    .src0_i      (src0_arch),
    .src1_i      (src1_arch),
    .dest_i      (dest_arch),
    .we_i        (alloc),
    .wpreg_i     (fl_preg),
    .wb_valid_i  (wb_valid_i),
    .wb_preg_i   (wb_preg_i),
    .psrc0_o     (rat_psrc0),
    .psrc1_o     (rat_psrc1),
    .ready0_o    (rat_ready0),
    .ready1_o    (rat_ready1),
    .old_pdest_o (rat_old)
  );

  // ====================
  // same-group bypass
  // ====================
  always_comb begin
    renamed_o = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      renamed_o[i].psrc0      = rat_psrc0[i];
      renamed_o[i].psrc1      = rat_psrc1[i];
      renamed_o[i].src0_ready = rat_ready0[i] | (src0_arch[i] == '0);
      renamed_o[i].src1_ready = rat_ready1[i] | (src1_arch[i] == '0);
      renamed_o[i].dest_valid = dest_vld[i];
      renamed_o[i].pdest      = dest_vld[i] ? fl_preg[i] : '0;
      renamed_o[i].old_pdest  = dest_vld[i] ? rat_old[i] : '0;
      // youngest older writer wins
      for (int j = 0; j < i; j++) begin
        if (dest_vld[j] && src0_arch[i] == dest_arch[j]) begin
          renamed_o[i].psrc0      = fl_preg[j];
          renamed_o[i].src0_ready = 1'b0;
        end
        if (dest_vld[j] && src1_arch[i] == dest_arch[j]) begin
          renamed_o[i].psrc1      = fl_preg[j];
          renamed_o[i].src1_ready = 1'b0;
        end
        if (dest_vld[i] && dest_vld[j] && dest_arch[i] == dest_arch[j]) begin
          renamed_o[i].old_pdest = fl_preg[j];
        end
      end
    end
  end

endmodule

/* src/excp_check.sv */
// exception classifier per decode slot, INT > INE > IPE > SYS > BRK
`timescale 1ns/10ps

module excp_check (
  input  sched_pkg::rename_req_t [sched_pkg::DECODE_WIDTH-1:0] req_i,
  input  logic                                                 csr_has_int_i,
  input  logic [1:0]                                           csr_plv_i,
  output sched_pkg::excp_t [sched_pkg::DECODE_WIDTH-1:0]       excp_o
);

  import isa_pkg::*;
  import sched_pkg::*;

  always_comb begin
    excp_o = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      // pending interrupt is taken on every slot
      if (csr_has_int_i) begin
        excp_o[i].valid = 1'b1;
        excp_o[i].ecode = ECODE_INT;
      end else if (req_i[i].invalid) begin
        excp_o[i].valid = 1'b1;
        excp_o[i].ecode = ECODE_INE;
      end else if (req_i[i].cls == CLS_PRIV && csr_plv_i == PLV_USER) begin
        excp_o[i].valid = 1'b1;
        excp_o[i].ecode = ECODE_IPE;
      end else if (req_i[i].cls == CLS_SYSCALL) begin
        excp_o[i].valid = 1'b1;
        excp_o[i].ecode = ECODE_SYS;
      end else if (req_i[i].cls == CLS_BREAK) begin
        excp_o[i].valid = 1'b1;
        excp_o[i].ecode = ECODE_BRK;
      end
    end
  end

endmodule

/* src/dispatch_merge.sv */
// merge stage, registers ROB entries and packs fault-free slots for dispatch
`timescale 1ns/10ps

module dispatch_merge (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     fire_i,
  input  sched_pkg::rename_req_t [sched_pkg::DECODE_WIDTH-1:0]     req_i,
  input  sched_pkg::renamed_t [sched_pkg::DECODE_WIDTH-1:0]        renamed_i,
  input  sched_pkg::excp_t [sched_pkg::DECODE_WIDTH-1:0]           excp_i,
  input  logic                                                     wb_valid_i,
  input  sched_pkg::phys_reg_t                                     wb_preg_i,
  output sched_pkg::rob_entry_t [sched_pkg::DECODE_WIDTH-1:0]      rob_o,
  output sched_pkg::dispatch_entry_t [sched_pkg::DECODE_WIDTH-1:0] dispatch_o
);

  import sched_pkg::*;

  logic [DECODE_WIDTH-1:0]            slot_fire;
  renamed_t [DECODE_WIDTH-1:0]        woke;
  rob_entry_t [DECODE_WIDTH-1:0]      rob_d;
  dispatch_entry_t [DECODE_WIDTH-1:0] disp_d;

  // writeback in this cycle would be missed by the table lookup
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      slot_fire[i] = fire_i & req_i[i].valid;
      woke[i]      = renamed_i[i];
      if (wb_valid_i && renamed_i[i].psrc0 == wb_preg_i) begin
        woke[i].src0_ready = 1'b1;
      end
      if (wb_valid_i && renamed_i[i].psrc1 == wb_preg_i) begin
        woke[i].src1_ready = 1'b1;
      end
    end
  end

  always_comb begin : merge_comb
    int pos;
    rob_d  = '0;
    disp_d = '0;
    pos    = 0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      if (slot_fire[i]) begin
        rob_d[i].valid     = 1'b1;
        rob_d[i].cls       = req_i[i].cls;
        rob_d[i].arch_dest = req_i[i].arch_dest;
        rob_d[i].pdest     = renamed_i[i].pdest;
        rob_d[i].old_pdest = renamed_i[i].old_pdest;
        rob_d[i].excp      = excp_i[i];
      end
      // faulting slots only retire through the ROB
      if (slot_fire[i] && !excp_i[i].valid) begin
        disp_d[pos].valid   = 1'b1;
        disp_d[pos].cls     = req_i[i].cls;
        disp_d[pos].renamed = woke[i];
        pos                 = pos + 1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rob_o      <= '0;
      dispatch_o <= '0;
    end else begin
      rob_o      <= rob_d;
      dispatch_o <= disp_d;
    end
  end

endmodule

/* src/rename_top.sv */
// rename front top, rename and exception paths side by side into the merge stage
`timescale 1ns/10ps

module rename_top (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  sched_pkg::rename_req_t [sched_pkg::DECODE_WIDTH-1:0]     req_i,
  input  logic                                                     csr_has_int_i,
  input  logic [1:0]                                               csr_plv_i,
  input  logic                                                     free_valid_i,
  input  sched_pkg::phys_reg_t                                     free_preg_i,
  input  logic                                                     wb_valid_i,
  input  sched_pkg::phys_reg_t                                     wb_preg_i,
  output logic                                                     req_ready_o,
  output sched_pkg::rob_entry_t [sched_pkg::DECODE_WIDTH-1:0]      rob_o,
  output sched_pkg::dispatch_entry_t [sched_pkg::DECODE_WIDTH-1:0] dispatch_o
);

  import sched_pkg::*;

  logic                          ren_ready;
  logic [DECODE_WIDTH-1:0]       req_valid;
  logic                          fire;
  renamed_t [DECODE_WIDTH-1:0]   renamed;
  excp_t [DECODE_WIDTH-1:0]      excp;

  assign req_ready_o = ren_ready;

  // group accepted when the free list can cover it
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      req_valid[i] = req_i[i].valid;
    end
    fire = ren_ready & (|req_valid);
  end

  rename_unit u_rename (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .fire_i       (fire),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .wb_valid_i   (wb_valid_i),
    .wb_preg_i    (wb_preg_i),
    .ready_o      (ren_ready),
    .renamed_o    (renamed)
  );

  excp_check u_excp (
    .req_i         (req_i),
    .csr_has_int_i (csr_has_int_i),
    .csr_plv_i     (csr_plv_i),
    .excp_o        (excp)
  );

  dispatch_merge u_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .fire_i     (fire),
    .req_i      (req_i),
    .renamed_i  (renamed),
    .excp_i     (excp),
    .wb_valid_i (wb_valid_i),
    .wb_preg_i  (wb_preg_i),
    .rob_o      (rob_o),
    .dispatch_o (dispatch_o)
  );

endmodule

/* sim/tb_rename_top.sv */
// testbench for the rename front, random decode groups checked against a reference model
`timescale 1ns/10ps

module tb_rename_top;

  import isa_pkg::*;
  import sched_pkg::*;

  localparam int NUM_CYCLES     = 1500;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 2000;
  // releases are withheld here so the free list runs dry
  localparam int HOLD_START     = 500;
  localparam int HOLD_END       = 600;

  logic                               clk;
  logic                               rst_n;
  rename_req_t [DECODE_WIDTH-1:0]     req;
  logic                               csr_has_int;
  logic [1:0]                         csr_plv;
  logic                               free_valid;
  phys_reg_t                          free_preg;
  logic                               wb_valid;
  phys_reg_t                          wb_preg;
  logic                               req_ready;
  rob_entry_t [DECODE_WIDTH-1:0]      rob;
  dispatch_entry_t [DECODE_WIDTH-1:0] disp;

  // ====================
  // reference model state
  // ====================
  phys_reg_t              model_map [ARCH_REG_NUM];
  logic [PHY_REG_NUM-1:0] model_rdy;
  phys_reg_t              free_q [$];
  phys_reg_t              pend_wb [$];
  phys_reg_t              pend_rel [$];

  rob_entry_t [DECODE_WIDTH-1:0]      exp_rob;
  dispatch_entry_t [DECODE_WIDTH-1:0] exp_disp;

  integer seed;
  int     cycle_cnt = 0;
  int     stall_cnt;
  int     recover_cnt;
  logic   hold_group;
  logic   last_ready;

  rename_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req),
    .csr_has_int_i (csr_has_int),
    .csr_plv_i     (csr_plv),
    .free_valid_i  (free_valid),
    .free_preg_i   (free_preg),
    .wb_valid_i    (wb_valid),
    .wb_preg_i     (wb_preg),
    .req_ready_o   (req_ready),
    .rob_o         (rob),
    .dispatch_o    (disp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on first error");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_with_error("run went past its cycle limit without finishing");
    end
  end

  task automatic check_rob(input string name, input rob_entry_t got, input rob_entry_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_dispatch(input string name, input dispatch_entry_t got,
                                input dispatch_entry_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic int unsigned rnd(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // first match wins: INT, INE, IPE, SYS, BRK
  function automatic excp_t classify(input rename_req_t r, input logic has_int,
                                     input logic [1:0] plv);
    excp_t e;
    e       = '0;
    e.valid = 1'b1;
    if (has_int)
      e.ecode = ECODE_INT;
    else if (r.invalid)
      e.ecode = ECODE_INE;
    else if (r.cls == CLS_PRIV && plv == PLV_USER)
      e.ecode = ECODE_IPE;
    else if (r.cls == CLS_SYSCALL)
      e.ecode = ECODE_SYS;
    else if (r.cls == CLS_BREAK)
      e.ecode = ECODE_BRK;
    else
      e = '0;
    return e;
  endfunction

  function automatic bit awaiting_wb(input phys_reg_t p);
    foreach (pend_wb[k]) begin
      if (pend_wb[k] == p) return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic check_outputs();
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      check_rob($sformatf("rob_o[%0d]", i), rob[i], exp_rob[i]);
      check_dispatch($sformatf("dispatch_o[%0d]", i), disp[i], exp_disp[i]);
    end
  endtask

  // checks the previous edge, then drives the next group and advances the model
  task automatic run_cycle(input int cyc, input bit directed);
    rename_req_t [DECODE_WIDTH-1:0] nreq;
    renamed_t rn;
    excp_t    ex;
    logic     model_ready;
    logic     fire;
    int       pos;
    int       k;

    @(posedge clk);
    #1;
    check_outputs();
    model_ready = (free_q.size() >= DECODE_WIDTH);
    check_ready("req_ready_o", req_ready, model_ready);
    if (model_ready && !last_ready) recover_cnt++;
    last_ready = model_ready;

    // ==================== stimulus
    nreq = req;
    if (directed) begin
      nreq = '0;
      nreq[0] = '{1'b1, CLS_ALU, 1'b0, arch_reg_t'(7), arch_reg_t'(9), arch_reg_t'(5)};
      nreq[1] = '{1'b1, CLS_MDU, 1'b0, arch_reg_t'(3), arch_reg_t'(4), arch_reg_t'(6)};
    end else if (!hold_group) begin
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        nreq[i].valid     = rnd(4) != 0;
        nreq[i].cls       = instr_class_e'(3'(rnd(4) == 0 ? rnd(7) : rnd(4)));
        nreq[i].invalid   = rnd(8) == 0;
        nreq[i].arch_src0 = arch_reg_t'(rnd(ARCH_REG_NUM));
        nreq[i].arch_src1 = arch_reg_t'(rnd(ARCH_REG_NUM));
        nreq[i].arch_dest = arch_reg_t'(rnd(ARCH_REG_NUM));
      end
      // slot 1 depends on slot 0 one time in four
      if (rnd(4) == 0) begin
        nreq[1].arch_dest = nreq[0].arch_dest;
        nreq[1].arch_src0 = nreq[0].arch_dest;
      end
    end
    req         = nreq;
    csr_has_int = directed ? 1'b0 : (rnd(16) == 0);
    csr_plv     = directed ? 2'd0 : 2'(rnd(4));

    wb_valid = 1'b0;
    wb_preg  = '0;
    if (pend_wb.size() > 0 && rnd(8) != 0) begin
      k        = rnd(pend_wb.size());
      wb_valid = 1'b1;
      wb_preg  = pend_wb[k];
      pend_wb.delete(k);
    end

    // a register is only released once it has been written back
    free_valid = 1'b0;
    free_preg  = '0;
    if ((cyc < HOLD_START || cyc >= HOLD_END) && rnd(4) != 0) begin
      for (k = 0; k < pend_rel.size(); k++) begin
        if (!awaiting_wb(pend_rel[k])) break;
      end
      if (k < pend_rel.size()) begin
        free_valid = 1'b1;
        free_preg  = pend_rel[k];
        pend_rel.delete(k);
      end
    end

    // ==================== model
    fire       = model_ready && (req[0].valid || req[1].valid);
    hold_group = !fire && (req[0].valid || req[1].valid);
    if (hold_group) stall_cnt++;
    exp_rob  = '0;
    exp_disp = '0;
    pos      = 0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      if (fire && req[i].valid) begin
        rn            = '0;
        rn.psrc0      = model_map[req[i].arch_src0];
        rn.psrc1      = model_map[req[i].arch_src1];
        rn.src0_ready = model_rdy[rn.psrc0] | (req[i].arch_src0 == '0);
        rn.src1_ready = model_rdy[rn.psrc1] | (req[i].arch_src1 == '0);
        if (req[i].arch_dest != '0) begin
          rn.dest_valid                = 1'b1;
          rn.pdest                     = free_q.pop_front();
          rn.old_pdest                 = model_map[req[i].arch_dest];
          model_map[req[i].arch_dest]  = rn.pdest;
          model_rdy[rn.pdest]          = 1'b0;
          pend_wb.push_back(rn.pdest);
          pend_rel.push_back(rn.old_pdest);
        end
        // writeback on this edge wakes the source too
        if (wb_valid && rn.psrc0 == wb_preg) rn.src0_ready = 1'b1;
        if (wb_valid && rn.psrc1 == wb_preg) rn.src1_ready = 1'b1;
        ex = classify(req[i], csr_has_int, csr_plv);
        exp_rob[i].valid     = 1'b1;
        exp_rob[i].cls       = req[i].cls;
        exp_rob[i].arch_dest = req[i].arch_dest;
        exp_rob[i].pdest     = rn.pdest;
        exp_rob[i].old_pdest = rn.old_pdest;
        exp_rob[i].excp      = ex;
        if (!ex.valid) begin
          exp_disp[pos].valid   = 1'b1;
          exp_disp[pos].cls     = req[i].cls;
          exp_disp[pos].renamed = rn;
          pos++;
        end
      end
    end
    if (wb_valid) model_rdy[wb_preg] = 1'b1;
    if (free_valid) free_q.push_back(free_preg);
  endtask

  initial begin
    dispatch_entry_t first_disp;
    rob_entry_t      first_rob;

    seed        = 32'h7f8d1f00;
    rst_n       = 1'b0;
    req         = '0;
    csr_has_int = 1'b0;
    csr_plv     = 2'd0;
    free_valid  = 1'b0;
    free_preg   = '0;
    wb_valid    = 1'b0;
    wb_preg     = '0;
    for (int a = 0; a < ARCH_REG_NUM; a++) begin
      model_map[a] = phys_reg_t'(a);
    end
    model_rdy = '1;
    for (int p = ARCH_REG_NUM; p < PHY_REG_NUM; p++) begin
      free_q.push_back(phys_reg_t'(p));
    end
    exp_rob     = '0;
    exp_disp    = '0;
    hold_group  = 1'b0;
    last_ready  = 1'b1;
    stall_cnt   = 0;
    recover_cnt = 0;

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    run_cycle(0, 1'b1);
    run_cycle(1, 1'b0);
    // first group takes 32 and 33 with identity-mapped ready sources
    first_rob  = '{1'b1, CLS_ALU, arch_reg_t'(5), phys_reg_t'(32), phys_reg_t'(5), excp_t'(0)};
    first_disp = '0;
    first_disp.valid   = 1'b1;
    first_disp.cls     = CLS_ALU;
    first_disp.renamed = '{phys_reg_t'(7), phys_reg_t'(9), 1'b1, 1'b1, 1'b1,
                           phys_reg_t'(32), phys_reg_t'(5)};
    check_rob("rob_o[0]", rob[0], first_rob);
    check_dispatch("dispatch_o[0]", disp[0], first_disp);
    first_disp.cls     = CLS_MDU;
    first_disp.renamed = '{phys_reg_t'(3), phys_reg_t'(4), 1'b1, 1'b1, 1'b1,
                           phys_reg_t'(33), phys_reg_t'(6)};
    check_dispatch("dispatch_o[1]", disp[1], first_disp);

    for (int cyc = 2; cyc < NUM_CYCLES; cyc++) begin
      run_cycle(cyc, 1'b0);
    end
    @(posedge clk);
    #1;
    check_outputs();

    if (stall_cnt == 0 || recover_cnt == 0) begin
      stop_with_error("free list never ran short and recovered during the run");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* Bender.yml */
package:
  name: rename_front

sources:
  - src/isa_pkg.sv
  - src/sched_pkg.sv
  - src/free_list.sv
  - src/reg_alias_table.sv
  - src/rename_unit.sv
  - src/excp_check.sv
  - src/dispatch_merge.sv
  - src/rename_top.sv
  - target: simulation
    files:
      - sim/tb_rename_top.sv

/* src.f */
src/isa_pkg.sv
src/sched_pkg.sv
src/free_list.sv
src/reg_alias_table.sv
src/rename_unit.sv
src/excp_check.sv
src/dispatch_merge.sv
src/rename_top.sv
sim/tb_rename_top.sv
